// ==== compile.f ====
source/tile_pkg.sv
source/flit_link_if.sv
source/mem_port_if.sv
source/tile_scratchpad.sv
source/mesh_router.sv
source/tile_chimney.sv
source/cluster_tile.sv
verification/tb_clock_gen.sv
verification/tb_cluster_tile.sv

// ==== Makefile ====
# Verilator flow for the cluster tile

TOP := tb_cluster_tile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module cluster_tile

sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/tb_cluster_tile.sv ====
////////////////////////////////////////
// Cluster tile testbench
// Table of flits through tile (1,1),
// output sinks with random ack delays
////////////////////////////////////////

`timescale 1ns/1ps

module tb_cluster_tile
  import tile_pkg::*;
();

  localparam int unsigned TableSize   = 24;
  localparam int unsigned NumGroups   = 17;
  localparam int unsigned GroupCycles = 200;
  localparam logic [31:0] Seed        = 32'hf3e5_23ba;
  localparam logic [CoordWidth-1:0] TileX = 2'd1;
  localparam logic [CoordWidth-1:0] TileY = 2'd1;

  logic                     clk;
  logic                     rst_n;
  logic [CoordWidth-1:0]    tile_x;
  logic [CoordWidth-1:0]    tile_y;
  flit_u [NumMeshPorts-1:0] flit_i;
  logic [NumMeshPorts-1:0]  req_i;
  logic [NumMeshPorts-1:0]  ack_o;
  flit_u [NumMeshPorts-1:0] flit_o;
  logic [NumMeshPorts-1:0]  req_o;
  logic [NumMeshPorts-1:0]  ack_i;

  // Stimulus table, PortLocal as output means consumed
  int unsigned             ent_group [TableSize];
  logic [PortIdxWidth-1:0] ent_in    [TableSize];
  flit_u                   ent_flit  [TableSize];
  logic [PortIdxWidth-1:0] ent_out   [TableSize];
  flit_u                   ent_exp   [TableSize];
  logic                    ent_slow  [TableSize];
  int unsigned             n_ent;

  logic [DataWidth-1:0]    model_mem [SpmDepth];
  flit_u                   rx_flit   [$];
  logic [PortIdxWidth-1:0] rx_dir    [$];
  logic [31:0]             rng_state;
  logic                    slow_ack;
  int unsigned             err_count;
  int unsigned             check_count;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cluster_tile uut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .tile_x_i (tile_x),
    .tile_y_i (tile_y),
    .flit_i   (flit_i),
    .req_i    (req_i),
    .ack_o    (ack_o),
    .flit_o   (flit_o),
    .req_o    (req_o),
    .ack_i    (ack_i)
  );

  ////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic string flit_text(input flit_u f);
    return $sformatf("dst=%0d,%0d src=%0d,%0d rsp=%0b wr=%0b addr=%0d data=%h",
                     f.req.dst_x, f.req.dst_y, f.req.src_x, f.req.src_y,
                     f.req.is_rsp, f.req.write, f.req.addr, f.req.wdata);
  endfunction

  // Response goes back to the requester
  function automatic flit_u response_for(input flit_u rq);
    flit_u rs;
    rs.rsp.dst_x  = rq.req.src_x;
    rs.rsp.dst_y  = rq.req.src_y;
    rs.rsp.src_x  = TileX;
    rs.rsp.src_y  = TileY;
    rs.rsp.is_rsp = 1'b1;
    rs.rsp.write  = rq.req.write;
    rs.rsp.addr   = rq.req.addr;
    rs.rsp.rdata  = rq.req.write ? '0 : model_mem[rq.req.addr];
    return rs;
  endfunction

  task automatic check_flit(input string name, input flit_u exp, input flit_u act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR %0t %s expected %s actual %s", $time, name, flit_text(exp),
               flit_text(act));
    end
  endtask

  task automatic check_port(input string name, input logic [PortIdxWidth-1:0] exp,
                            input logic [PortIdxWidth-1:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic expect_low(input string name, input logic [NumMeshPorts-1:0] act);
    check_count++;
    if (act !== '0) begin
      err_count++;
      $display("ERR %0t %s expected %b actual %b", $time, name, {NumMeshPorts{1'b0}}, act);
    end
  endtask

  task automatic add_entry(input int unsigned grp, input logic [PortIdxWidth-1:0] in_dir,
                           input logic [1:0] dx, input logic [1:0] dy,
                           input logic [1:0] sx, input logic [1:0] sy,
                           input logic rsp, input logic wr, input logic [5:0] addr,
                           input logic [PortIdxWidth-1:0] out_dir, input logic slow);
    flit_u f;
    f.req.dst_x  = dx;
    f.req.dst_y  = dy;
    f.req.src_x  = sx;
    f.req.src_y  = sy;
    f.req.is_rsp = rsp;
    f.req.write  = wr;
    f.req.addr   = addr;
    f.req.wdata  = next_rand();
    ent_group[n_ent] = grp;
    ent_in[n_ent]    = in_dir;
    ent_flit[n_ent]  = f;
    ent_out[n_ent]   = out_dir;
    ent_slow[n_ent]  = slow;
    if (!rsp && dx == TileX && dy == TileY) begin
      ent_exp[n_ent] = response_for(f);
      if (wr) begin
        model_mem[addr] = f.req.wdata;
      end
    end else begin
      ent_exp[n_ent] = f;
    end
    n_ent++;
  endtask

  task automatic build_table();
    // Pass-through, x ties fall to Y
    add_entry(0, PortWest, 3, 2, 0, 1, 0, 0, 0, PortEast, 0);
    add_entry(1, PortEast, 0, 0, 3, 1, 0, 0, 0, PortWest, 0);
    add_entry(2, PortSouth, 1, 3, 1, 0, 0, 0, 0, PortNorth, 0);
    add_entry(3, PortNorth, 1, 0, 2, 3, 0, 0, 0, PortSouth, 0);
    add_entry(4, PortWest, 2, 1, 0, 0, 0, 0, 0, PortEast, 0);
    // Local writes and read-back
    add_entry(5, PortNorth, 1, 1, 1, 3, 0, 1, 5, PortNorth, 0);
    add_entry(6, PortWest, 1, 1, 0, 2, 0, 1, 9, PortWest, 0);
    add_entry(7, PortSouth, 1, 1, 2, 0, 0, 0, 5, PortEast, 0);
    add_entry(8, PortEast, 1, 1, 3, 1, 1, 0, 0, PortLocal, 0);
    add_entry(9, PortEast, 1, 1, 1, 0, 0, 0, 9, PortSouth, 0);
    // Two and three inputs on one output
    add_entry(10, PortNorth, 3, 1, 1, 2, 0, 0, 0, PortEast, 0);
    add_entry(10, PortWest, 2, 3, 0, 1, 0, 0, 0, PortEast, 0);
    add_entry(11, PortEast, 0, 3, 2, 2, 0, 0, 0, PortWest, 0);
    add_entry(11, PortSouth, 0, 0, 1, 0, 0, 0, 0, PortWest, 0);
    add_entry(11, PortNorth, 0, 1, 1, 2, 0, 0, 0, PortWest, 0);
    // Held outputs with long ack delays
    add_entry(12, PortWest, 1, 2, 0, 1, 0, 0, 0, PortNorth, 1);
    add_entry(12, PortSouth, 1, 3, 1, 0, 0, 0, 0, PortNorth, 1);
    add_entry(12, PortEast, 1, 3, 2, 1, 0, 0, 0, PortNorth, 1);
    add_entry(13, PortEast, 1, 1, 3, 3, 0, 1, 63, PortEast, 1);
    add_entry(13, PortNorth, 2, 2, 1, 3, 0, 0, 0, PortEast, 1);
    add_entry(14, PortNorth, 1, 1, 2, 3, 1, 1, 7, PortLocal, 0);
    add_entry(15, PortWest, 1, 1, 0, 0, 0, 0, 63, PortWest, 0);
    add_entry(16, PortSouth, 1, 1, 1, 3, 0, 0, 5, PortNorth, 1);
    add_entry(16, PortWest, 1, 0, 0, 2, 0, 0, 0, PortSouth, 1);
  endtask

  ////////////////////////////////////////
  // Link drivers
  ////////////////////////////////////////

  task automatic send_flit(input logic [PortIdxWidth-1:0] dir, input flit_u f);
    int unsigned cycles;
    @(negedge clk);
    flit_i[dir[1:0]] = f;
    req_i[dir[1:0]]  = 1'b1;
    cycles = 0;
    while (!ack_o[dir[1:0]] && cycles < GroupCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!ack_o[dir[1:0]]) begin
      err_count++;
      $display("%0t: input %0d never saw ack_o rise", $time, dir);
    end
    req_i[dir[1:0]] = 1'b0;
    cycles = 0;
    while (ack_o[dir[1:0]] && cycles < GroupCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (ack_o[dir[1:0]]) begin
      err_count++;
      $display("%0t: input %0d kept ack_o high after req_i fell", $time, dir);
    end
  endtask

  // Sink for one mesh output
  task automatic serve_output(input int d);
    flit_u       held;
    int unsigned delay;
    forever begin
      @(negedge clk);
      if (req_o[d] === 1'b1) begin
        held  = flit_o[d];
        delay = slow_ack ? (next_rand() & 32'd31) : (next_rand() & 32'd7);
        repeat (delay) begin
          @(negedge clk);
          if (flit_o[d] !== held) begin
            check_flit("flit_o while req_o high", held, flit_o[d]);
          end
        end
        ack_i[d] = 1'b1;
        rx_flit.push_back(flit_o[d]);
        rx_dir.push_back(PortIdxWidth'(d));
        while (req_o[d] === 1'b1) begin
          @(negedge clk);
        end
        ack_i[d] = 1'b0;
      end
    end
  endtask

  for (genvar d = 0; d < NumMeshPorts; d++) begin : g_sink
    initial serve_output(d);
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  task automatic run_group(input int unsigned g);
    int unsigned first_err;
    int unsigned n_exp;
    int unsigned cycles;
    int          idx;
    first_err = err_count;
    n_exp     = 0;
    slow_ack  = 1'b0;
    for (int i = 0; i < n_ent; i++) begin
      if (ent_group[i] == g) begin
        slow_ack = slow_ack | ent_slow[i];
        if (ent_out[i] != PortLocal) begin
          n_exp++;
        end
      end
    end
    for (int i = 0; i < n_ent; i++) begin
      if (ent_group[i] == g) begin
        automatic int k = i;
        fork
          send_flit(ent_in[k], ent_flit[k]);
        join_none
      end
    end
    wait fork;
    cycles = 0;
    while (rx_flit.size() < n_exp && cycles < GroupCycles) begin
      @(negedge clk);
      cycles++;
    end
    // Arrival order is free, match by content
    for (int i = 0; i < n_ent; i++) begin
      if (ent_group[i] == g && ent_out[i] != PortLocal) begin
        idx = -1;
        foreach (rx_flit[j]) begin
          if (idx < 0 && rx_flit[j] === ent_exp[i]) begin
            idx = j;
          end
        end
        if (idx < 0 && rx_flit.size() > 0) begin
          idx = 0;
        end
        if (idx < 0) begin
          err_count++;
          $display("%0t: test %0d got no output flit for table entry %0d", $time, g, i);
        end else begin
          check_port("output port", ent_out[i], rx_dir[idx]);
          check_flit("flit_o", ent_exp[i], rx_flit[idx]);
          rx_flit.delete(idx);
          rx_dir.delete(idx);
        end
      end
    end
    if (rx_flit.size() > 0) begin
      err_count++;
      $display("%0t: test %0d saw %0d unexpected output flits", $time, g, rx_flit.size());
      rx_flit.delete();
      rx_dir.delete();
    end
    $display("test %0d: %s", g, (err_count == first_err) ? "ok" : "FAIL");
  endtask

  initial begin
    flit_i      = '0;
    req_i       = '0;
    ack_i       = '0;
    tile_x      = TileX;
    tile_y      = TileY;
    rng_state   = Seed;
    slow_ack    = 1'b0;
    err_count   = 0;
    check_count = 0;
    n_ent       = 0;
    build_table();
    @(posedge rst_n);
    @(negedge clk);
    expect_low("req_o", req_o);
    expect_low("ack_o", ack_o);
    $display("test reset: %s", (err_count == 0) ? "ok" : "FAIL");
    for (int unsigned g = 0; g < NumGroups; g++) begin
      run_group(g);
    end
    $display("%0d tests, %0d checks, %0d errors", NumGroups + 1, check_count, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TableSize * 200) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", TableSize * 200);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset
// 40 ns clock, reset low for 8 cycles
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int unsigned HalfPeriod  = 20;
  localparam int unsigned ResetCycles = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  // Released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== source/cluster_tile.sv ====
////////////////////////////////////////
// Cluster tile
// Router, chimney and scratchpad of one
// tile in the 4x4 mesh
////////////////////////////////////////

`timescale 1ns/1ps

module cluster_tile
  import tile_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic  [CoordWidth-1:0]             tile_x_i,
  input  logic  [CoordWidth-1:0]             tile_y_i,
  // Mesh ports, North..West
  input  flit_u [NumMeshPorts-1:0]           flit_i,
  input  logic  [NumMeshPorts-1:0]           req_i,
  output logic  [NumMeshPorts-1:0]           ack_o,
  output flit_u [NumMeshPorts-1:0]           flit_o,
  output logic  [NumMeshPorts-1:0]           req_o,
  input  logic  [NumMeshPorts-1:0]           ack_i
);

  flit_link_if in_link  [NumPorts] ();
  flit_link_if out_link [NumPorts] ();
  mem_port_if  mem_port ();

  for (genvar p = 0; p < NumMeshPorts; p++) begin : g_mesh
    assign in_link[p].flit = flit_i[p];
    assign in_link[p].req  = req_i[p];
    assign ack_o[p]        = in_link[p].ack;
    assign flit_o[p]       = out_link[p].flit;
    assign req_o[p]        = out_link[p].req;
    assign out_link[p].ack = ack_i[p];
  end

  mesh_router i_router (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .tile_x_i (tile_x_i),
    .tile_y_i (tile_y_i),
    .in_link  (in_link),
    .out_link (out_link)
  );

  // Local port runs through the chimney
  tile_chimney i_chimney (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .tile_x_i (tile_x_i),
    .tile_y_i (tile_y_i),
    .eject    (out_link[PortLocal]),
    .inject   (in_link[PortLocal]),
    .mem      (mem_port)
  );

  tile_scratchpad i_scratchpad (
    .clk_i (clk_i),
    .mem   (mem_port)
  );

endmodule

// ==== source/tile_chimney.sv ====
////////////////////////////////////////
// Tile chimney
// Serves ejected requests from the
// scratchpad, injects the responses
////////////////////////////////////////

`timescale 1ns/1ps

module tile_chimney
  import tile_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [CoordWidth-1:0] tile_x_i,
  input  logic [CoordWidth-1:0] tile_y_i,
  flit_link_if.receiver         eject,
  flit_link_if.sender           inject,
  mem_port_if.master            mem
);

  logic [ChimStateWidth-1:0] state_q;
  logic                      eject_ack_q;
  logic                      inject_req_q;
  logic                      accept;
  flit_u                     req_flit_q;
  flit_u                     rsp_flit;

  // New flits only taken while idle
  assign accept = (state_q == ChimIdle) && eject.req && !eject_ack_q;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= ChimIdle;
      eject_ack_q  <= 1'b0;
      inject_req_q <= 1'b0;
    end else begin
      if (eject_ack_q && !eject.req) begin
        eject_ack_q <= 1'b0;
      end
      case (state_q)
        ChimIdle: begin
          if (accept) begin
            eject_ack_q <= 1'b1;
            // Responses end here
            if (!eject.flit.req.is_rsp) begin
              state_q <= ChimAccess;
            end
          end
        end
        ChimAccess: begin
          state_q      <= ChimSend;
          inject_req_q <= 1'b1;
        end
        ChimSend: begin
          if (inject.ack) begin
            inject_req_q <= 1'b0;
            state_q      <= ChimWaitAckLow;
          end
        end
        default: begin
          if (!inject.ack) begin
            state_q <= ChimIdle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_flit_q <= eject.flit;
    end
  end

  ////////////////////////////////////////
  // Scratchpad and response
  ////////////////////////////////////////

  assign mem.en    = (state_q == ChimAccess);
  assign mem.we    = req_flit_q.req.write;
  assign mem.addr  = req_flit_q.req.addr;
  assign mem.wdata = req_flit_q.req.wdata;

  // rdata holds still until the next access
  always_comb begin
    rsp_flit.rsp.dst_x  = req_flit_q.req.src_x;
    rsp_flit.rsp.dst_y  = req_flit_q.req.src_y;
    rsp_flit.rsp.src_x  = tile_x_i;
    rsp_flit.rsp.src_y  = tile_y_i;
    rsp_flit.rsp.is_rsp = 1'b1;
    rsp_flit.rsp.write  = req_flit_q.req.write;
    rsp_flit.rsp.addr   = req_flit_q.req.addr;
    rsp_flit.rsp.rdata  = req_flit_q.req.write ? '0 : mem.rdata;
  end

  assign eject.ack   = eject_ack_q;
  assign inject.req  = inject_req_q;
  assign inject.flit = rsp_flit;

endmodule

// ==== source/mesh_router.sv ====
////////////////////////////////////////
// Mesh router
// Five ports, one-flit input buffers,
// XY routing, round-robin per output
////////////////////////////////////////

`timescale 1ns/1ps

module mesh_router
  import tile_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [CoordWidth-1:0] tile_x_i,
  input  logic [CoordWidth-1:0] tile_y_i,
  flit_link_if.receiver         in_link  [NumPorts],
  flit_link_if.sender           out_link [NumPorts]
);

  // Input side
  flit_u                   in_flit     [NumPorts];
  logic [NumPorts-1:0]     in_req;
  logic [NumPorts-1:0]     in_ack_q;
  flit_u                   buf_q       [NumPorts];
  logic [NumPorts-1:0]     buf_valid_q;
  logic [PortIdxWidth-1:0] route_d     [NumPorts];
  logic [PortIdxWidth-1:0] buf_route_q [NumPorts];
  logic [NumPorts-1:0]     capture;
  logic [NumPorts-1:0]     release_in;

  // Output side
  flit_u                   out_flit_q  [NumPorts];
  logic [NumPorts-1:0]     out_req_q;
  logic [NumPorts-1:0]     out_busy_q;
  logic [NumPorts-1:0]     out_ack;
  logic [PortIdxWidth-1:0] out_sel_q   [NumPorts];
  logic [PortIdxWidth-1:0] rr_ptr_q    [NumPorts];
  logic [NumPorts-1:0]     grant_valid;
  logic [PortIdxWidth-1:0] grant_idx   [NumPorts];

  for (genvar p = 0; p < NumPorts; p++) begin : g_link
    assign in_flit[p]       = in_link[p].flit;
    assign in_req[p]        = in_link[p].req;
    assign in_link[p].ack   = in_ack_q[p];
    assign out_link[p].flit = out_flit_q[p];
    assign out_link[p].req  = out_req_q[p];
    assign out_ack[p]       = out_link[p].ack;
  end

  ////////////////////////////////////////
  // Input buffers and XY route
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      capture[i] = in_req[i] && !in_ack_q[i] && !buf_valid_q[i];
      // X first, then Y
      if (in_flit[i].req.dst_x > tile_x_i) begin
        route_d[i] = PortEast;
      end else if (in_flit[i].req.dst_x < tile_x_i) begin
        route_d[i] = PortWest;
      end else if (in_flit[i].req.dst_y > tile_y_i) begin
        route_d[i] = PortNorth;
      end else if (in_flit[i].req.dst_y < tile_y_i) begin
        route_d[i] = PortSouth;
      end else begin
        route_d[i] = PortLocal;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_ack_q    <= '0;
      buf_valid_q <= '0;
    end else begin
      for (int i = 0; i < NumPorts; i++) begin
        if (capture[i]) begin
          in_ack_q[i]    <= 1'b1;
          buf_valid_q[i] <= 1'b1;
        end else begin
          if (!in_req[i]) begin
            in_ack_q[i] <= 1'b0;
          end
          if (release_in[i]) begin
            buf_valid_q[i] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumPorts; i++) begin
      if (capture[i]) begin
        buf_q[i]       <= in_flit[i];
        buf_route_q[i] <= route_d[i];
      end
    end
  end

  ////////////////////////////////////////
  // Output arbiters
  ////////////////////////////////////////

  // Closest requester at or after the pointer wins
  always_comb begin
    int unsigned cand;
    for (int o = 0; o < NumPorts; o++) begin
      grant_valid[o] = 1'b0;
      grant_idx[o]   = '0;
      for (int k = NumPorts - 1; k >= 0; k--) begin
        cand = int'(rr_ptr_q[o]) + k;
        if (cand >= NumPorts) begin
          cand = cand - NumPorts;
        end
        if (buf_valid_q[cand] && (buf_route_q[cand] == PortIdxWidth'(o))) begin
          grant_valid[o] = 1'b1;
          grant_idx[o]   = PortIdxWidth'(cand);
        end
      end
    end
  end

  // Buffer freed once downstream ack is low again
  always_comb begin
    release_in = '0;
    for (int o = 0; o < NumPorts; o++) begin
      if (out_busy_q[o] && !out_req_q[o] && !out_ack[o]) begin
        release_in[out_sel_q[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_req_q  <= '0;
      out_busy_q <= '0;
      for (int o = 0; o < NumPorts; o++) begin
        rr_ptr_q[o] <= '0;
      end
    end else begin
      for (int o = 0; o < NumPorts; o++) begin
        if (!out_busy_q[o]) begin
          if (grant_valid[o]) begin
            out_busy_q[o] <= 1'b1;
            out_req_q[o]  <= 1'b1;
            rr_ptr_q[o]   <= (grant_idx[o] == PortIdxWidth'(NumPorts - 1)) ?
                             '0 : grant_idx[o] + 1'b1;
          end
        end else if (out_req_q[o]) begin
          if (out_ack[o]) begin
            out_req_q[o] <= 1'b0;
          end
        end else if (!out_ack[o]) begin
          out_busy_q[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (!out_busy_q[o] && grant_valid[o]) begin
        out_flit_q[o] <= buf_q[grant_idx[o]];
        out_sel_q[o]  <= grant_idx[o];
      end
    end
  end

endmodule

// ==== source/tile_scratchpad.sv ====
////////////////////////////////////////
// Tile scratchpad
// 64 x 32 single port, one-cycle read
////////////////////////////////////////

`timescale 1ns/1ps

module tile_scratchpad
  import tile_pkg::*;
(
  input logic        clk_i,
  mem_port_if.slave  mem
);

  logic [DataWidth-1:0] ram_q [SpmDepth];
  logic [DataWidth-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (mem.en && mem.we) begin
      ram_q[mem.addr] <= mem.wdata;
    end
    // Read word lands one cycle after en
    if (mem.en && !mem.we) begin
      rdata_q <= ram_q[mem.addr];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

// ==== source/mem_port_if.sv ====
////////////////////////////////////////
// Scratchpad access port
// rdata valid the cycle after a read
////////////////////////////////////////

`timescale 1ns/1ps

interface mem_port_if
  import tile_pkg::*;
();

  logic                 en;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] wdata;
  logic [DataWidth-1:0] rdata;

  modport master (output en, output we, output addr, output wdata, input rdata);

  modport slave (input en, input we, input addr, input wdata, output rdata);

endinterface

// ==== source/flit_link_if.sv ====
////////////////////////////////////////
// Flit link
// One flit with a four-phase req/ack
////////////////////////////////////////

`timescale 1ns/1ps

interface flit_link_if
  import tile_pkg::*;
();

  flit_u flit;
  logic  req;
  logic  ack;

  // Flit held stable while req is high
  modport sender (
    output flit,
    output req,
    input  ack
  );

  modport receiver (
    input  flit,
    input  req,
    output ack
  );

endinterface

// ==== source/tile_pkg.sv ====
////////////////////////////////////////
// Tile package
// Mesh geometry, port indices, chimney
// state codes and the two-view flit word
////////////////////////////////////////

package tile_pkg;

  // Mesh and scratchpad geometry
  localparam int unsigned CoordWidth = 2;
  localparam int unsigned AddrWidth  = 6;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned FlitWidth  = 48;
  localparam int unsigned SpmDepth   = 64;

  ////////////////////////////////////////
  // Router ports
  ////////////////////////////////////////

  localparam int unsigned NumPorts     = 5;
  localparam int unsigned NumMeshPorts = 4;
  localparam int unsigned PortIdxWidth = 3;

  // y grows toward North, x toward East
  localparam logic [PortIdxWidth-1:0] PortNorth = 3'd0;
  localparam logic [PortIdxWidth-1:0] PortEast  = 3'd1;
  localparam logic [PortIdxWidth-1:0] PortSouth = 3'd2;
  localparam logic [PortIdxWidth-1:0] PortWest  = 3'd3;
  localparam logic [PortIdxWidth-1:0] PortLocal = 3'd4;

  // Chimney FSM encoding
  localparam int unsigned ChimStateWidth = 2;
  localparam logic [ChimStateWidth-1:0] ChimIdle       = 2'd0;
  localparam logic [ChimStateWidth-1:0] ChimAccess     = 2'd1;
  localparam logic [ChimStateWidth-1:0] ChimSend       = 2'd2;
  localparam logic [ChimStateWidth-1:0] ChimWaitAckLow = 2'd3;

  ////////////////////////////////////////
  // Flit word
  ////////////////////////////////////////

  // Header sits at the same bits in both views
  typedef union packed {
    struct packed {
      logic [CoordWidth-1:0] dst_x;
      logic [CoordWidth-1:0] dst_y;
      logic [CoordWidth-1:0] src_x;
      logic [CoordWidth-1:0] src_y;
      logic                  is_rsp;
      logic                  write;
      logic [AddrWidth-1:0]  addr;
      logic [DataWidth-1:0]  wdata;
    } req;
    struct packed {
      logic [CoordWidth-1:0] dst_x;
      logic [CoordWidth-1:0] dst_y;
      logic [CoordWidth-1:0] src_x;
      logic [CoordWidth-1:0] src_y;
      logic                  is_rsp;
      logic                  write;
      logic [AddrWidth-1:0]  addr;
      logic [DataWidth-1:0]  rdata;
    } rsp;
  } flit_u;

endpackage
